/* Makefile */
# Verilator build for the stream block processor testbench.
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

SRCS := $(wildcard rtl/*.sv bench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_top.sv */
/*
 * Testbench for the stream block processor. Drives random words through the DUT under
 * each mask setting and compares every output word with a queue model of the mask rule.
 */
`timescale 1ns/1ps

module tb_top;

    import stream_pkg::*;

    localparam int    CLK_PERIOD      = 8;
    localparam int    WORDS_PER_TEST  = 64;
    localparam int    NUM_TESTS       = 4;
    localparam int    TOTAL_WORDS     = WORDS_PER_TEST * NUM_TESTS;
    localparam int    WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 1000;
    localparam word_t SEED            = 32'd84452;

    logic       clk_i;
    logic       rstn_i;
    word_t      s_tdata_i;
    logic       s_tvalid_i;
    logic       s_tready_o;
    word_t      m_tdata_o;
    logic       m_tvalid_o;
    logic       m_tready_i;
    logic       cfg_we_i;
    cfg_addr_t  cfg_addr_i;
    word_t      cfg_wdata_i;
    word_t      cfg_rdata_o;

    word_t      data_rng;
    word_t      ready_rng;
    word_t      model_key [LANES];
    logic [1:0] model_ctrl;
    word_t      grp_q [$];   // accepted words of the open group.
    word_t      exp_q [$];
    int         err_cnt = 0;
    int         check_cnt = 0;
    int         cycle_cnt = 0;
    int         words_out = 0;
    int         last_in_cycle = 0;
    int         first_out_cycle = 0;

    block_proc_top i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .s_tdata_i   (s_tdata_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tready_o  (s_tready_o),
        .m_tdata_o   (m_tdata_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_tready_i  (m_tready_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t expected_readback(input cfg_addr_t addr);
        if (addr < ADDR_CTRL) begin
            return model_key[addr[1:0]];
        end else if (addr == ADDR_CTRL) begin
            return word_t'(model_ctrl);
        end
        return '0;   // unmapped.
    endfunction

    task automatic check_word(input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: m_tdata_o = 0x%08h, expected 0x%08h", $time, got, exp);
        end
    endtask

    task automatic check_cfg(input cfg_addr_t addr, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: cfg_rdata_o (addr %0d) = 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("Error at %0t ns: first output latency = %0d cycles, expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // expected words for each full group of four.
    task automatic model_accept(input word_t w);
        int    j;
        word_t src;
        grp_q.push_back(w);
        if (grp_q.size() == LANES) begin
            for (j = 0; j < LANES; j++) begin
                src = model_ctrl[CTRL_REV_BIT] ? grp_q[LANES-1-j] : grp_q[j];
                if (model_ctrl[CTRL_XOR_BIT]) begin
                    src = src ^ model_key[j];
                end
                exp_q.push_back(src);
            end
            grp_q.delete();
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input word_t data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_we_i    <= 1'b0;
        if (addr < ADDR_CTRL) begin
            model_key[addr[1:0]] = data;
        end else if (addr == ADDR_CTRL) begin
            model_ctrl = data[1:0];
        end
    endtask

    task automatic cfg_read_check(input cfg_addr_t addr);
        @(posedge clk_i);
        cfg_addr_i <= addr;
        @(negedge clk_i);
        check_cfg(addr, cfg_rdata_o, expected_readback(addr));
    endtask

    task automatic load_random_keys();
        int j;
        for (j = 0; j < LANES; j++) begin
            data_rng = xorshift32(data_rng);
            cfg_write(cfg_addr_t'(int'(ADDR_KEY0) + j), data_rng);
        end
    endtask

    task automatic send_words(input int n, input bit gaps, input bit measure);
        int    k;
        int    idle;
        word_t w;
        @(posedge clk_i);
        for (k = 0; k < n; k++) begin
            if (gaps) begin
                data_rng = xorshift32(data_rng);
                idle = int'(data_rng[1:0]);
                repeat (idle) begin
                    s_tvalid_i <= 1'b0;
                    @(posedge clk_i);
                end
            end
            data_rng = xorshift32(data_rng);
            w = data_rng;
            s_tdata_i  <= w;
            s_tvalid_i <= 1'b1;
            @(posedge clk_i);
            while (!s_tready_o) @(posedge clk_i);
            model_accept(w);
            if (measure && k == LANES - 1) begin
                last_in_cycle = cycle_cnt;
            end
        end
        s_tvalid_i <= 1'b0;
    endtask

    task automatic receive_words(input int n, input bit stalls, input bit measure);
        int k;
        k = 0;
        @(posedge clk_i);
        while (k < n) begin
            if (stalls) begin
                ready_rng = xorshift32(ready_rng);
                m_tready_i <= (ready_rng[2:0] > 3'd2);   // ready about 5 cycles in 8.
            end else begin
                m_tready_i <= 1'b1;
            end
            @(posedge clk_i);
            if (m_tvalid_o && m_tready_i) begin
                if (measure && k == 0) begin
                    first_out_cycle = cycle_cnt;
                end
                if (exp_q.size() == 0) begin
                    report_failure("output word arrived while no word was expected");
                end else begin
                    check_word(m_tdata_o, exp_q.pop_front());
                end
                k++;
                words_out++;
            end
        end
        m_tready_i <= 1'b1;
    endtask

    // pipeline must be empty once every expected word is out.
    task automatic check_drained();
        repeat (6) begin
            @(negedge clk_i);
            check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
        end
    endtask

    task automatic run_stream(input bit gaps, input bit stalls, input bit measure);
        fork
            send_words(WORDS_PER_TEST, gaps, measure);
            receive_words(WORDS_PER_TEST, stalls, measure);
        join
        check_drained();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles: output stalled with %0d of %0d words received",
                 WATCHDOG_CYCLES, words_out, TOTAL_WORDS);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        $display("Test failed");
        $finish;
    end

    initial begin
        int a;
        rstn_i      <= 1'b0;
        s_tdata_i   <= '0;
        s_tvalid_i  <= 1'b0;
        m_tready_i  <= 1'b1;
        cfg_we_i    <= 1'b0;
        cfg_addr_i  <= '0;
        cfg_wdata_i <= '0;
        data_rng   = SEED;
        ready_rng  = xorshift32(SEED ^ 32'h2545f491);
        model_ctrl = '0;
        for (a = 0; a < LANES; a++) begin
            model_key[a] = '0;
        end
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;

        @(negedge clk_i);
        check_flag("m_tvalid_o", m_tvalid_o, 1'b0);
        check_flag("s_tready_o", s_tready_o, 1'b1);

        run_stream(1'b0, 1'b0, 1'b1);   // pass-through with latency measured.
        check_latency(first_out_cycle - last_in_cycle, 3);

        load_random_keys();
        cfg_write(ADDR_CTRL, word_t'(1) << CTRL_XOR_BIT);
        run_stream(1'b0, 1'b0, 1'b0);

        cfg_write(ADDR_CTRL, word_t'(1) << CTRL_REV_BIT);
        run_stream(1'b0, 1'b0, 1'b0);

        load_random_keys();
        cfg_write(ADDR_CTRL, (word_t'(1) << CTRL_REV_BIT) | (word_t'(1) << CTRL_XOR_BIT));
        run_stream(1'b1, 1'b1, 1'b0);   // gaps and back-pressure.

        for (a = 0; a <= int'(ADDR_CTRL); a++) begin
            data_rng = xorshift32(data_rng);
            cfg_write(cfg_addr_t'(a), data_rng);
        end
        for (a = 0; a <= int'(ADDR_CTRL); a++) begin
            cfg_read_check(cfg_addr_t'(a));
        end
        for (a = int'(ADDR_CTRL) + 1; a < 8; a++) begin
            data_rng = xorshift32(data_rng);
            cfg_write(cfg_addr_t'(a), data_rng);
        end
        for (a = 0; a < 8; a++) begin
            cfg_read_check(cfg_addr_t'(a));   // unmapped writes must leave no trace.
        end

        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d, words out: %0d of %0d",
                 check_cnt, err_cnt, words_out, TOTAL_WORDS);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/stream_pkg.sv
rtl/axis_if.sv
rtl/axis_dw_conv.sv
rtl/lane_mask_unit.sv
rtl/mask_cfg_regs.sv
rtl/block_proc_top.sv
bench/tb_top.sv

/* rtl/axis_dw_conv.sv */
/*
 * Stream width converter. Gathers narrow words into a wide beat, splits a wide beat
 * into narrow words, or passes through when both widths are equal. Lane 0 goes first.
 */
`timescale 1ns/1ps

module axis_dw_conv #(
    parameter int DATA_WIDTH_IN  = 32,
    parameter int DATA_WIDTH_OUT = 128
) (
    axis_if.master m_axis,
    axis_if.slave  s_axis
);

    logic clk;
    logic rstn;
    logic s_hs;
    logic m_hs;

    assign clk  = s_axis.clk_i;
    assign rstn = s_axis.rstn_i;
    assign s_hs = s_axis.tvalid & s_axis.tready;
    assign m_hs = m_axis.tvalid & m_axis.tready;

    if (DATA_WIDTH_IN > DATA_WIDTH_OUT) begin : g_downsize
        localparam int RATIO = DATA_WIDTH_IN / DATA_WIDTH_OUT;

        logic [$clog2(RATIO)-1:0]                    lane_idx;
        logic                                        last_lane;
        logic                                        busy;
        logic [RATIO-1:0][DATA_WIDTH_OUT-1:0]        data_q;

        assign last_lane = (lane_idx == RATIO - 1);

        always_ff @(posedge clk) begin
            if (!rstn) begin
                lane_idx <= '0;
            end else if (m_hs) begin
                lane_idx <= last_lane ? '0 : lane_idx + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                busy <= 1'b0;
            end else if (s_hs) begin
                busy <= 1'b1;
            end else if (m_hs && last_lane) begin
                busy <= 1'b0;   // idle after the last lane.
            end
        end

        // whole input latched while idle.
        always_ff @(posedge clk) begin
            if (s_hs) begin
                data_q <= s_axis.tdata;
            end
        end

        assign m_axis.tdata  = data_q[lane_idx];
        assign m_axis.tvalid = busy;
        assign s_axis.tready = ~busy;

    end else if (DATA_WIDTH_IN < DATA_WIDTH_OUT) begin : g_upsize
        localparam int RATIO = DATA_WIDTH_OUT / DATA_WIDTH_IN;

        logic [$clog2(RATIO)-1:0]                    lane_idx;
        logic                                        last_lane;
        logic                                        valid_q;
        logic [RATIO-1:0][DATA_WIDTH_IN-1:0]         data_q;

        assign last_lane = (lane_idx == RATIO - 1);

        always_ff @(posedge clk) begin
            if (!rstn) begin
                lane_idx <= '0;
            end else if (s_hs) begin
                lane_idx <= last_lane ? '0 : lane_idx + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_q <= 1'b0;
            end else if (s_hs && last_lane) begin
                valid_q <= 1'b1;
            end else if (m_hs) begin
                valid_q <= 1'b0;
            end
        end

        // a new lane 0 can only land when the held beat leaves.
        always_ff @(posedge clk) begin
            if (s_hs) begin
                data_q[lane_idx] <= s_axis.tdata;
            end
        end

        assign m_axis.tdata  = data_q;
        assign m_axis.tvalid = valid_q;
        assign s_axis.tready = m_axis.tready;

    end else begin : g_bypass
        assign m_axis.tdata  = s_axis.tdata;
        assign m_axis.tvalid = s_axis.tvalid;
        assign s_axis.tready = m_axis.tready;
    end

endmodule

/* rtl/axis_if.sv */
/*
 * Valid/ready stream bundle with its clock and reset.
 * Master drives tdata and tvalid, slave answers with tready.
 */
`timescale 1ns/1ps

interface axis_if #(
    parameter int DATA_WIDTH = 32
) (
    input logic clk_i,
    input logic rstn_i
);

    logic [DATA_WIDTH-1:0] tdata;
    logic                  tvalid;
    logic                  tready;

    modport master (
        input  clk_i,
        input  rstn_i,
        input  tready,
        output tdata,
        output tvalid
    );

    modport slave (
        input  clk_i,
        input  rstn_i,
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

/* rtl/block_proc_top.sv */
/*
 * Stream block processor: gathers four words into a block, masks it, and splits it again.
 * Plain stream and configuration ports; internal stages are joined by stream interfaces.
 */
`timescale 1ns/1ps

module block_proc_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  stream_pkg::word_t       s_tdata_i,
    input  logic                    s_tvalid_i,
    output logic                    s_tready_o,
    output stream_pkg::word_t       m_tdata_o,
    output logic                    m_tvalid_o,
    input  logic                    m_tready_i,
    input  logic                    cfg_we_i,
    input  stream_pkg::cfg_addr_t   cfg_addr_i,
    input  stream_pkg::word_t       cfg_wdata_i,
    output stream_pkg::word_t       cfg_rdata_o
);

    import stream_pkg::*;

    word_t [LANES-1:0] key;
    logic              xor_en;
    logic              rev_en;

    axis_if #(.DATA_WIDTH(WORD_W)) in_if (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    axis_if #(.DATA_WIDTH(BLOCK_W)) blk_if (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    axis_if #(.DATA_WIDTH(BLOCK_W)) msk_if (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    axis_if #(.DATA_WIDTH(WORD_W)) out_if (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    // top-level ports onto the edge interfaces.
    assign in_if.tdata   = s_tdata_i;
    assign in_if.tvalid  = s_tvalid_i;
    assign s_tready_o    = in_if.tready;

    assign m_tdata_o     = out_if.tdata;
    assign m_tvalid_o    = out_if.tvalid;
    assign out_if.tready = m_tready_i;

    axis_dw_conv #(
        .DATA_WIDTH_IN  (WORD_W),
        .DATA_WIDTH_OUT (BLOCK_W)
    ) i_upsize (
        .m_axis (blk_if.master),
        .s_axis (in_if.slave)
    );

    lane_mask_unit i_mask (
        .s_axis   (blk_if.slave),
        .m_axis   (msk_if.master),
        .key_i    (key),
        .xor_en_i (xor_en),
        .rev_en_i (rev_en)
    );

    mask_cfg_regs i_cfg (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .key_o       (key),
        .xor_en_o    (xor_en),
        .rev_en_o    (rev_en)
    );

    axis_dw_conv #(
        .DATA_WIDTH_IN  (BLOCK_W),
        .DATA_WIDTH_OUT (WORD_W)
    ) i_downsize (
        .m_axis (out_if.master),
        .s_axis (msk_if.slave)
    );

endmodule

/* rtl/lane_mask_unit.sv */
/*
 * Single-slot register stage that reverses lane order and XORs each lane with a key word
 * as a block enters. Accepts a new block in the cycle the held one leaves.
 */
`timescale 1ns/1ps

module lane_mask_unit (
    axis_if.slave                                       s_axis,
    axis_if.master                                      m_axis,
    input  stream_pkg::word_t [stream_pkg::LANES-1:0]   key_i,
    input  logic                                        xor_en_i,
    input  logic                                        rev_en_i
);

    import stream_pkg::*;

    logic                 clk;
    logic                 rstn;
    logic                 s_hs;
    logic                 m_hs;
    word_t [LANES-1:0]    in_lanes;
    word_t [LANES-1:0]    sel_lanes;
    word_t [LANES-1:0]    mask_lanes;
    block_t               masked;
    block_t               data_q;
    logic                 valid_q;

    assign clk  = s_axis.clk_i;
    assign rstn = s_axis.rstn_i;
    assign s_hs = s_axis.tvalid & s_axis.tready;
    assign m_hs = m_axis.tvalid & m_axis.tready;

    assign in_lanes = s_axis.tdata;

    // output lane j from lane 3-j when reversed, then keyed.
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            sel_lanes[j]  = rev_en_i ? in_lanes[LANES-1-j] : in_lanes[j];
            mask_lanes[j] = xor_en_i ? (sel_lanes[j] ^ key_i[j]) : sel_lanes[j];
        end
    end

    assign masked = mask_lanes;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (s_hs) begin
            valid_q <= 1'b1;
        end else if (m_hs) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_hs) begin
            data_q <= masked;
        end
    end

    assign s_axis.tready = ~valid_q | m_axis.tready;   // empty or draining.
    assign m_axis.tdata  = data_q;
    assign m_axis.tvalid = valid_q;

endmodule

/* rtl/mask_cfg_regs.sv */
/*
 * Key and control registers for the lane mask unit.
 * Written by strobe and address; readback is combinational from the address.
 */
`timescale 1ns/1ps

module mask_cfg_regs (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic                                        cfg_we_i,
    input  stream_pkg::cfg_addr_t                       cfg_addr_i,
    input  stream_pkg::word_t                           cfg_wdata_i,
    output stream_pkg::word_t                           cfg_rdata_o,
    output stream_pkg::word_t [stream_pkg::LANES-1:0]   key_o,
    output logic                                        xor_en_o,
    output logic                                        rev_en_o
);

    import stream_pkg::*;

    word_t [LANES-1:0] key_q;
    logic  [1:0]       ctrl_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            key_q  <= '0;
            ctrl_q <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                ADDR_KEY0: key_q[0] <= cfg_wdata_i;
                ADDR_KEY1: key_q[1] <= cfg_wdata_i;
                ADDR_KEY2: key_q[2] <= cfg_wdata_i;
                ADDR_KEY3: key_q[3] <= cfg_wdata_i;
                ADDR_CTRL: begin
                    ctrl_q[CTRL_XOR_BIT] <= cfg_wdata_i[CTRL_XOR_BIT];
                    ctrl_q[CTRL_REV_BIT] <= cfg_wdata_i[CTRL_REV_BIT];
                end
                default: ;   // write to an unmapped address is dropped.
            endcase
        end
    end

    always_comb begin
        case (cfg_addr_i)
            ADDR_KEY0: cfg_rdata_o = key_q[0];
            ADDR_KEY1: cfg_rdata_o = key_q[1];
            ADDR_KEY2: cfg_rdata_o = key_q[2];
            ADDR_KEY3: cfg_rdata_o = key_q[3];
            ADDR_CTRL: cfg_rdata_o = {{(WORD_W-2){1'b0}}, ctrl_q};
            default:   cfg_rdata_o = '0;
        endcase
    end

    assign key_o    = key_q;
    assign xor_en_o = ctrl_q[CTRL_XOR_BIT];
    assign rev_en_o = ctrl_q[CTRL_REV_BIT];

endmodule

/* rtl/stream_pkg.sv */
/*
 * Widths, configuration register map and vector types shared by the block processor.
 * Modules import it inside their body; port lists use scoped names.
 */
package stream_pkg;

    localparam int WORD_W     = 32;
    localparam int LANES      = 4;
    localparam int BLOCK_W    = WORD_W * LANES;
    localparam int CFG_ADDR_W = 3;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BLOCK_W-1:0]    block_t;   // lane 0 in the low word.
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

    // configuration register map.
    localparam cfg_addr_t ADDR_KEY0 = 3'd0;
    localparam cfg_addr_t ADDR_KEY1 = 3'd1;
    localparam cfg_addr_t ADDR_KEY2 = 3'd2;
    localparam cfg_addr_t ADDR_KEY3 = 3'd3;
    localparam cfg_addr_t ADDR_CTRL = 3'd4;

    // control register fields.
    localparam int CTRL_XOR_BIT = 0;
    localparam int CTRL_REV_BIT = 1;

endpackage
